/* rtl/fetch_pkg.sv */
// fetch front end shared definitions
// word and table geometry, counter encoding, RV32I opcodes, decode
// enums and the instruction word with its R, I, S and B views
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and table geometry
	////////////////////////////////////////////////////////////////////////////
	localparam int XLEN = 32;                           // machine word
	typedef logic [XLEN-1:0] word_t;                    // pc, target, data

	localparam int BHT_IDX_BITS = 4;                    // pc[5:2]
	localparam int BHT_ENTRIES  = 1 << BHT_IDX_BITS;
	localparam int GHR_BITS     = 4;                    // global history length
	localparam int BTB_IDX_BITS = 4;                    // pc[5:2]
	localparam int BTB_ENTRIES  = 1 << BTB_IDX_BITS;
	localparam int BTB_TAG_BITS = XLEN - BTB_IDX_BITS - 2; // pc[31:6]

	typedef logic [1:0] ctr_t;                          // 2-bit saturating counter
	localparam ctr_t CTR_MIN     = 2'd0;                // strong not taken
	localparam ctr_t CTR_WEAK_NT = 2'd1;                // reset state
	localparam ctr_t CTR_MAX     = 2'd3;                // strong taken, bit 1 = taken

	localparam logic [4:0] ZERO_REG    = 5'd0;          // x0, no destination
	localparam word_t      EBREAK_WORD = 32'h0010_0073;

	////////////////////////////////////////////////////////////////////////////
	// RV32I base opcodes
	////////////////////////////////////////////////////////////////////////////
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_func_t;

	typedef enum logic [1:0] {FU_ALU, FU_MEM, FU_BRANCH, FU_NONE} fu_type_t;

	typedef enum logic {DEST_RD, DEST_NONE} dest_sel_t;

	// one 32-bit word, four field layouts
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic [6:0] imm_hi;                 // imm[12|10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;                 // imm[4:1|11]
			logic [6:0] opcode;
		} b;
	} inst_t;

endpackage

`default_nettype wire

/* rtl/branch_resolve_if.sv */
// resolved branch bundle
// one branch outcome from the back end, driven by the fetch top and
// read by the direction predictor and the BTB
`timescale 1ns/1ns
`default_nettype none

interface branch_resolve_if;
	import fetch_pkg::*;

	word_t result_pc;                   // pc of the resolved branch
	logic  result_cond_branch;          // strobe, conditional branch
	logic  result_uncond_branch;        // strobe, jal / jalr
	word_t result_target_pc;            // actual target
	logic  result_taken;
	logic  result_local_taken;          // what local table predicted
	logic  result_global_taken;         // what global table predicted

	modport source (
		output result_pc, result_cond_branch, result_uncond_branch, result_target_pc,
		output result_taken, result_local_taken, result_global_taken
	);

	modport learner (
		input result_pc, result_cond_branch, result_uncond_branch, result_target_pc,
		input result_taken, result_local_taken, result_global_taken
	);

endinterface

`default_nettype wire

/* rtl/tournament_predictor.sv */
// tournament branch direction predictor
// local and gshare-style global 2-bit counter tables, with a chooser
// table picking between them per pc; trained by resolved conditional
// branches, history shifted on the same strobe
`timescale 1ns/1ns
`default_nettype none

module tournament_predictor (
	input  wire                   clock,
	input  wire                   reset,
	input  wire fetch_pkg::word_t fetch_pc,
	input  wire                   fetch_cond_branch,
	branch_resolve_if.learner     resolve,
	output logic                  pred_taken,
	output logic                  pred_local_taken,
	output logic                  pred_global_taken
);
	import fetch_pkg::*;

	ctr_t local_tbl  [BHT_ENTRIES];            // per-pc counters
	ctr_t global_tbl [BHT_ENTRIES];            // pc xor history
	ctr_t choice_tbl [BHT_ENTRIES];            // >= 2 trusts global

	logic [GHR_BITS-1:0]     ghr;              // newest outcome in bit 0
	logic [BHT_IDX_BITS-1:0] fetch_idx;
	logic [BHT_IDX_BITS-1:0] fetch_gidx;
	logic [BHT_IDX_BITS-1:0] update_idx;
	logic [BHT_IDX_BITS-1:0] update_gidx;

	// one step toward up/down, held at the ends
	function automatic ctr_t ctr_step(input ctr_t c, input logic up);
		if (up)
			return (c == CTR_MAX) ? c : c + 2'd1;
		return (c == CTR_MIN) ? c : c - 2'd1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////
	assign fetch_idx  = fetch_pc[BHT_IDX_BITS+1:2];
	assign fetch_gidx = fetch_idx ^ ghr;

	assign pred_local_taken  = local_tbl[fetch_idx][1];  // msb = taken
	assign pred_global_taken = global_tbl[fetch_gidx][1];

	// chooser only matters for conditional branches
	assign pred_taken = fetch_cond_branch &&
		(choice_tbl[fetch_idx][1] ? pred_global_taken : pred_local_taken);

	////////////////////////////////////////////////////////////////////////////
	// training
	////////////////////////////////////////////////////////////////////////////
	assign update_idx  = resolve.result_pc[BHT_IDX_BITS+1:2];
	assign update_gidx = update_idx ^ ghr;     // history before this shift

	always_ff @(posedge clock) begin
		if (reset) begin
			ghr <= '0;
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				local_tbl[i]  <= CTR_WEAK_NT;
				global_tbl[i] <= CTR_WEAK_NT;
				choice_tbl[i] <= CTR_WEAK_NT;
			end
		end else if (resolve.result_cond_branch) begin
			local_tbl[update_idx]   <= ctr_step(local_tbl[update_idx], resolve.result_taken);
			global_tbl[update_gidx] <= ctr_step(global_tbl[update_gidx],
				resolve.result_taken);
			// chooser learns only when the two tables disagreed
			if (resolve.result_local_taken != resolve.result_global_taken)
				choice_tbl[update_idx] <= ctr_step(choice_tbl[update_idx],
					resolve.result_global_taken == resolve.result_taken);
			ghr <= {ghr[GHR_BITS-2:0], resolve.result_taken};
		end
	end

	// counters saturate instead of wrapping out of 0..3
	local_sat_high: assert property (@(posedge clock) disable iff (reset)
		resolve.result_cond_branch && resolve.result_taken &&
		local_tbl[update_idx] == CTR_MAX
		|=> local_tbl[$past(update_idx)] == CTR_MAX);

	global_sat_low: assert property (@(posedge clock) disable iff (reset)
		resolve.result_cond_branch && !resolve.result_taken &&
		global_tbl[update_gidx] == CTR_MIN
		|=> global_tbl[$past(update_gidx)] == CTR_MIN);

endmodule

`default_nettype wire

/* rtl/branch_target_buffer.sv */
// direct-mapped branch target buffer
// 16 entries of valid, tag and target, looked up with the fetch pc and
// written by every taken resolved branch
`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer (
	input  wire                   clock,
	input  wire                   reset,
	input  wire fetch_pkg::word_t fetch_pc,
	branch_resolve_if.learner     resolve,
	output logic                  btb_hit,
	output fetch_pkg::word_t      btb_target
);
	import fetch_pkg::*;

	logic                    valid_tbl  [BTB_ENTRIES];
	logic [BTB_TAG_BITS-1:0] tag_tbl    [BTB_ENTRIES];
	word_t                   target_tbl [BTB_ENTRIES];

	logic [BTB_IDX_BITS-1:0] fetch_idx;
	logic [BTB_TAG_BITS-1:0] fetch_tag;
	logic [BTB_IDX_BITS-1:0] wr_idx;
	logic                    wr_en;

	////////////////////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////////////////////
	assign fetch_idx = fetch_pc[BTB_IDX_BITS+1:2];
	assign fetch_tag = fetch_pc[XLEN-1:BTB_IDX_BITS+2];   // pc[31:6]

	assign btb_hit    = valid_tbl[fetch_idx] && (tag_tbl[fetch_idx] == fetch_tag);
	assign btb_target = target_tbl[fetch_idx];            // qualified by hit

	////////////////////////////////////////////////////////////////////////////
	// fill on taken resolve
	////////////////////////////////////////////////////////////////////////////
	assign wr_idx = resolve.result_pc[BTB_IDX_BITS+1:2];
	assign wr_en  = resolve.result_taken &&
		(resolve.result_cond_branch || resolve.result_uncond_branch);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BTB_ENTRIES; i++)
				valid_tbl[i] <= 1'b0;
		end else if (wr_en) begin
			valid_tbl[wr_idx] <= 1'b1;
		end
	end

	// tag and target of each fill
	always_ff @(posedge clock) begin
		if (wr_en) begin
			tag_tbl[wr_idx]    <= resolve.result_pc[XLEN-1:BTB_IDX_BITS+2];
			target_tbl[wr_idx] <= resolve.result_target_pc;
		end
	end

	// back end never flags one branch as both kinds
	single_kind: assert property (@(posedge clock) disable iff (reset)
		!(resolve.result_cond_branch && resolve.result_uncond_branch));

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
// RV32I instruction decoder
// combinational; opcode with funct3, plus funct7 bit 5 for register ops
// and shifts, gives ALU function, unit, destination select and flags
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
	input  wire fetch_pkg::inst_t   inst,
	input  wire                     inst_valid,
	output fetch_pkg::alu_func_t    alu_func,
	output fetch_pkg::fu_type_t     fu_type,
	output fetch_pkg::dest_sel_t    dest_sel,
	output logic                    rd_mem,
	output logic                    wr_mem,
	output logic                    cond_branch,
	output logic                    uncond_branch,
	output logic                    halt,
	output logic                    illegal
);
	import fetch_pkg::*;

	// shared funct3 map of OP_IMM and OP_REG
	function automatic alu_func_t arith_func(input logic [2:0] f3, input logic alt,
		input logic is_reg);
		case (f3)
			3'd0:    return (is_reg && alt) ? ALU_SUB : ALU_ADD; // no subi
			3'd1:    return ALU_SLL;
			3'd2:    return ALU_SLT;
			3'd3:    return ALU_SLTU;
			3'd4:    return ALU_XOR;
			3'd5:    return alt ? ALU_SRA : ALU_SRL;
			3'd6:    return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		alu_func      = ALU_ADD;
		fu_type       = FU_NONE;
		dest_sel      = DEST_NONE;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (inst_valid) begin
			case (inst.r.opcode)
				OP_LUI, OP_AUIPC: begin
					fu_type  = FU_ALU;
					dest_sel = DEST_RD;
				end
				OP_JAL, OP_JALR: begin          // link into rd
					fu_type       = FU_BRANCH;
					dest_sel      = DEST_RD;
					uncond_branch = 1'b1;
				end
				OP_BRANCH: begin
					fu_type     = FU_BRANCH;
					cond_branch = 1'b1;
					case (inst.b.funct3[2:1])       // compare kind
						2'b10:   alu_func = ALU_SLT;  // blt / bge
						2'b11:   alu_func = ALU_SLTU; // bltu / bgeu
						default: alu_func = ALU_SUB;  // beq / bne
					endcase
				end
				OP_LOAD: begin
					fu_type  = FU_MEM;
					dest_sel = DEST_RD;
					rd_mem   = 1'b1;
				end
				OP_STORE: begin                 // address add only
					fu_type = FU_MEM;
					wr_mem  = 1'b1;
				end
				OP_IMM: begin
					fu_type  = FU_ALU;
					dest_sel = DEST_RD;
					alu_func = arith_func(inst.i.funct3, inst.r.funct7[5], 1'b0);
				end
				OP_REG: begin
					fu_type  = FU_ALU;
					dest_sel = DEST_RD;
					alu_func = arith_func(inst.r.funct3, inst.r.funct7[5], 1'b1);
				end
				OP_SYSTEM: halt = (inst == EBREAK_WORD); // ecall etc. pass as nops
				default:   illegal = 1'b1;
			endcase
		end
	end

	// halt and a branch never leave together
	halt_no_branch: assert final (!halt || (!cond_branch && !uncond_branch));

endmodule

`default_nettype wire

/* rtl/fetch_stage.sv */
// instruction fetch stage, top level
// holds the pc, looks up direction predictor and BTB, decodes the
// fetched word and picks the next pc; resolved branches from the back
// end train both predictors, a mispredict redirects and squashes
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
	input  wire                   clock,
	input  wire                   reset,
	input  wire fetch_pkg::word_t imem_data,
	input  wire                   imem_valid,
	input  wire fetch_pkg::word_t result_pc,
	input  wire                   result_cond_branch,
	input  wire                   result_uncond_branch,
	input  wire fetch_pkg::word_t result_target_pc,
	input  wire                   result_taken,
	input  wire                   result_local_taken,
	input  wire                   result_global_taken,
	input  wire                   result_mis_pred,
	output fetch_pkg::word_t      imem_addr,
	output logic                  id_valid,
	output fetch_pkg::word_t      id_pc,
	output fetch_pkg::word_t      id_npc,
	output fetch_pkg::word_t      id_inst,
	output logic [4:0]            id_rs1,
	output logic [4:0]            id_rs2,
	output logic [4:0]            id_rd,
	output fetch_pkg::alu_func_t  id_alu_func,
	output fetch_pkg::fu_type_t   id_fu_type,
	output logic                  id_rd_mem,
	output logic                  id_wr_mem,
	output logic                  id_cond_branch,
	output logic                  id_uncond_branch,
	output logic                  id_halt,
	output logic                  id_illegal,
	output logic                  id_branch_prediction,
	output logic                  id_local_taken,
	output logic                  id_global_taken
);
	import fetch_pkg::*;

	word_t     pc;                     // pc being fetched
	word_t     next_pc;
	word_t     btb_target;
	logic      btb_hit;
	logic      pred_taken;
	logic      take_target;
	inst_t     inst;
	dest_sel_t dest_sel;

	branch_resolve_if resolve ();

	// back end outcome onto the shared bundle
	assign resolve.result_pc            = result_pc;
	assign resolve.result_cond_branch   = result_cond_branch;
	assign resolve.result_uncond_branch = result_uncond_branch;
	assign resolve.result_target_pc     = result_target_pc;
	assign resolve.result_taken         = result_taken;
	assign resolve.result_local_taken   = result_local_taken;
	assign resolve.result_global_taken  = result_global_taken;

	tournament_predictor u_predictor (
		.clock             (clock),
		.reset             (reset),
		.fetch_pc          (pc),
		.fetch_cond_branch (id_cond_branch),
		.resolve           (resolve),
		.pred_taken        (pred_taken),
		.pred_local_taken  (id_local_taken),
		.pred_global_taken (id_global_taken)
	);

	branch_target_buffer u_btb (
		.clock      (clock),
		.reset      (reset),
		.fetch_pc   (pc),
		.resolve    (resolve),
		.btb_hit    (btb_hit),
		.btb_target (btb_target)
	);

	inst_decoder u_decoder (
		.inst          (inst),
		.inst_valid    (id_valid),     // squashed words decode as nothing
		.alu_func      (id_alu_func),
		.fu_type       (id_fu_type),
		.dest_sel      (dest_sel),
		.rd_mem        (id_rd_mem),
		.wr_mem        (id_wr_mem),
		.cond_branch   (id_cond_branch),
		.uncond_branch (id_uncond_branch),
		.halt          (id_halt),
		.illegal       (id_illegal)
	);

	////////////////////////////////////////////////////////////////////////////
	// decode packet
	////////////////////////////////////////////////////////////////////////////
	assign inst      = imem_data;
	assign imem_addr = {pc[XLEN-1:2], 2'b00};   // word aligned
	assign id_valid  = imem_valid && !result_mis_pred;
	assign id_pc     = pc;
	assign id_npc    = next_pc;
	assign id_inst   = imem_data;
	assign id_rs1    = inst.r.rs1;
	assign id_rs2    = inst.r.rs2;
	assign id_rd     = (dest_sel == DEST_NONE) ? ZERO_REG : inst.r.rd;

	assign id_branch_prediction = btb_hit && pred_taken;

	////////////////////////////////////////////////////////////////////////////
	// next pc
	////////////////////////////////////////////////////////////////////////////
	// jumps need only a btb hit, cond branches also a taken prediction
	assign take_target = btb_hit && (id_uncond_branch || (id_cond_branch && pred_taken));
	assign next_pc     = take_target ? btb_target : pc + 32'd4;

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (result_mis_pred)
			pc <= result_target_pc;      // redirect from back end
		else if (imem_valid)
			pc <= next_pc;               // otherwise hold while memory stalls
	end

	no_issue_on_mispred: assert property (@(posedge clock) disable iff (reset)
		result_mis_pred |-> !id_valid);

endmodule

`default_nettype wire

/* sim/fetch_tb.sv */
// fetch front end testbench
// drives the fetch top through reset, stall, decode, training, jump and
// mispredict tests; mirror tables give the expected packet every cycle
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int    TIMEOUT      = 50;             // cycles per wait
	localparam word_t ADDI_WORD    = 32'h0010_0093;  // addi x1, x0, 1
	localparam word_t BEQ_WORD     = 32'h0020_8463;  // beq x1, x2, +8
	localparam word_t JAL_WORD     = 32'h0080_00ef;  // jal x1, +8
	localparam word_t TRAIN_PC     = 32'h0000_0148;  // index 2
	localparam word_t TRAIN_TARGET = 32'h0000_0800;
	localparam word_t JUMP_PC      = 32'h0000_0224;  // index 9
	localparam word_t JUMP_TARGET  = 32'h0000_0900;
	localparam word_t REDIRECT_PC  = 32'h0000_0a00;

	typedef struct packed {
		alu_func_t  alu;
		fu_type_t   fu;
		logic [4:0] rd;
		logic       rd_mem, wr_mem, cond, uncond, halt, illegal;
	} dec_t;

	logic       clock, reset, imem_valid, result_cond_branch, result_uncond_branch;
	logic       result_taken, result_local_taken, result_global_taken, result_mis_pred;
	logic       id_valid, id_rd_mem, id_wr_mem, id_cond_branch, id_uncond_branch;
	logic       id_halt, id_illegal, id_branch_prediction, id_local_taken, id_global_taken;
	word_t      imem_data, imem_addr, result_pc, result_target_pc, id_pc, id_npc, id_inst;
	logic [4:0] id_rs1, id_rs2, id_rd;
	alu_func_t  id_alu_func;
	fu_type_t   id_fu_type;

	ctr_t                    m_local  [BHT_ENTRIES];   // mirror predictor
	ctr_t                    m_global [BHT_ENTRIES];
	ctr_t                    m_choice [BHT_ENTRIES];
	logic [GHR_BITS-1:0]     m_ghr;
	logic                    m_valid  [BTB_ENTRIES];   // mirror btb
	logic [BTB_TAG_BITS-1:0] m_tag    [BTB_ENTRIES];
	word_t                   m_target [BTB_ENTRIES];
	word_t                   m_pc;                     // expected fetch pc

	integer seed = 28950;
	string  cur_test;
	int     n_tests = 0;
	int     n_checks = 0;
	int     n_errors = 0;
	int     t_checks, t_errors;                        // totals at test start

	fetch_stage DUT (.*);

	always #20 clock = ~clock;                         // 40 ns period

	////////////////////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////////////////////
	function automatic ctr_t counter_step(input ctr_t c, input logic up);
		if (up)
			return (c == 2'd3) ? c : c + 2'd1;
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	function automatic dec_t ref_decode(input word_t w);
		dec_t d;
		logic writes_rd;
		d         = '0;
		d.fu      = FU_NONE;
		writes_rd = 1'b1;
		case (w[6:0])
			OP_LUI, OP_AUIPC: d.fu = FU_ALU;
			OP_JAL, OP_JALR: begin
				d.fu     = FU_BRANCH;
				d.uncond = 1'b1;
			end
			OP_BRANCH: begin                   // compare through the alu
				d.fu      = FU_BRANCH;
				d.cond    = 1'b1;
				writes_rd = 1'b0;
				d.alu     = !w[14] ? ALU_SUB : (w[13] ? ALU_SLTU : ALU_SLT);
			end
			OP_LOAD: begin
				d.fu     = FU_MEM;
				d.rd_mem = 1'b1;
			end
			OP_STORE: begin
				d.fu      = FU_MEM;
				d.wr_mem  = 1'b1;
				writes_rd = 1'b0;
			end
			OP_IMM, OP_REG: begin
				d.fu = FU_ALU;
				case (w[14:12])
					3'd0: d.alu = (w[6:0] == OP_REG && w[30]) ? ALU_SUB : ALU_ADD;
					3'd1: d.alu = ALU_SLL;
					3'd2: d.alu = ALU_SLT;
					3'd3: d.alu = ALU_SLTU;
					3'd4: d.alu = ALU_XOR;
					3'd5: d.alu = w[30] ? ALU_SRA : ALU_SRL;
					3'd6: d.alu = ALU_OR;
					3'd7: d.alu = ALU_AND;
				endcase
			end
			OP_SYSTEM: begin
				d.halt    = (w == EBREAK_WORD);
				writes_rd = 1'b0;
			end
			default: begin
				d.illegal = 1'b1;
				writes_rd = 1'b0;
			end
		endcase
		d.rd = writes_rd ? w[11:7] : ZERO_REG;
		return d;
	endfunction

	// expected npc from the mirror tables, plus the three prediction bits
	function automatic word_t ref_predict(input word_t pc, input logic cond,
		input logic uncond, output logic pred, output logic loc, output logic glob);
		logic [3:0] idx;
		logic       taken;
		logic       hit;
		idx   = pc[5:2];
		loc   = m_local[idx] >= 2'd2;
		glob  = m_global[idx ^ m_ghr] >= 2'd2;
		taken = cond && ((m_choice[idx] >= 2'd2) ? glob : loc);
		hit   = m_valid[idx] && (m_tag[idx] == pc[31:6]);
		pred  = hit && taken;
		return (hit && (uncond || taken)) ? m_target[idx] : pc + 32'd4;
	endfunction

	always @(posedge clock) begin : mirror
		dec_t       d;
		word_t      npc;
		logic       p, l, g;
		logic [3:0] ui;
		if (reset) begin
			m_pc  = '0;
			m_ghr = '0;
			for (int i = 0; i < 16; i++) begin
				m_local[i]  = CTR_WEAK_NT;
				m_global[i] = CTR_WEAK_NT;
				m_choice[i] = CTR_WEAK_NT;
				m_valid[i]  = 1'b0;
			end
		end else begin
			d   = ref_decode(imem_data);
			npc = ref_predict(m_pc, d.cond, d.uncond, p, l, g);   // before training
			if (result_mis_pred)
				m_pc = result_target_pc;
			else if (imem_valid)
				m_pc = npc;
			ui = result_pc[5:2];
			if (result_cond_branch) begin
				m_local[ui]          = counter_step(m_local[ui], result_taken);
				m_global[ui ^ m_ghr] = counter_step(m_global[ui ^ m_ghr], result_taken);
				if (result_local_taken != result_global_taken)
					m_choice[ui] = counter_step(m_choice[ui],
						result_global_taken == result_taken);
				m_ghr = {m_ghr[2:0], result_taken};
			end
			if (result_taken && (result_cond_branch || result_uncond_branch)) begin
				m_valid[ui]  = 1'b1;
				m_tag[ui]    = result_pc[31:6];
				m_target[ui] = result_target_pc;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks and per-cycle checker
	////////////////////////////////////////////////////////////////////////////
	task automatic tally(input logic ok, input string what, input string e, input string a);
		n_checks++;
		if (!ok) begin
			n_errors++;
			$display("[FAIL] %s: %s expected %s actual %s", cur_test, what, e, a);
		end
	endtask

	task automatic check_word(input string what, input word_t e, input word_t a);
		tally(a === e, what, $sformatf("%h", e), $sformatf("%h", a));
	endtask

	task automatic check_reg(input string what, input logic [4:0] e, input logic [4:0] a);
		tally(a === e, what, $sformatf("x%0d", e), $sformatf("x%0d", a));
	endtask

	task automatic check_alu(input string what, input alu_func_t e, input alu_func_t a);
		tally(a === e, what, e.name(), a.name());
	endtask

	task automatic check_fu(input string what, input fu_type_t e, input fu_type_t a);
		tally(a === e, what, e.name(), a.name());
	endtask

	task automatic check_bit(input string what, input logic e, input logic a);
		tally(a === e, what, $sformatf("%b", e), $sformatf("%b", a));
	endtask

	always @(negedge clock) begin : compare           // outputs settled mid-cycle
		dec_t  d;
		word_t npc;
		logic  p, l, g;
		logic  exp_valid;
		if (!reset) begin
			exp_valid = imem_valid && !result_mis_pred;
			check_word("imem_addr", m_pc, imem_addr);
			check_bit("id_valid", exp_valid, id_valid);
			if (exp_valid) begin
				d   = ref_decode(imem_data);
				npc = ref_predict(m_pc, d.cond, d.uncond, p, l, g);
				check_word("id_pc", m_pc, id_pc);
				check_word("id_npc", npc, id_npc);
				check_word("id_inst", imem_data, id_inst);
				check_reg("id_rs1", imem_data[19:15], id_rs1);
				check_reg("id_rs2", imem_data[24:20], id_rs2);
				check_reg("id_rd", d.rd, id_rd);
				check_alu("id_alu_func", d.alu, id_alu_func);
				check_fu("id_fu_type", d.fu, id_fu_type);
				check_bit("id_rd_mem", d.rd_mem, id_rd_mem);
				check_bit("id_wr_mem", d.wr_mem, id_wr_mem);
				check_bit("id_cond_branch", d.cond, id_cond_branch);
				check_bit("id_uncond_branch", d.uncond, id_uncond_branch);
				check_bit("id_halt", d.halt, id_halt);
				check_bit("id_illegal", d.illegal, id_illegal);
				check_bit("id_branch_prediction", p, id_branch_prediction);
				check_bit("id_local_taken", l, id_local_taken);
				check_bit("id_global_taken", g, id_global_taken);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic start_test(input string name);
		cur_test = name;
		t_checks = n_checks;
		t_errors = n_errors;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %-10s %0d checks, %0d errors", cur_test,
			n_checks - t_checks, n_errors - t_errors);
	endtask

	task automatic drive_fetch(input word_t data, input logic valid);
		@(posedge clock);
		imem_data  <= data;
		imem_valid <= valid;
	endtask

	// one taken resolve, strobes dropped on the following edge
	task automatic drive_resolve(input word_t pc, input word_t target, input logic uncond,
		input logic loc, input logic glob);
		@(posedge clock);
		imem_valid           <= 1'b0;
		result_pc            <= pc;
		result_target_pc     <= target;
		result_cond_branch   <= !uncond;
		result_uncond_branch <= uncond;
		result_taken         <= 1'b1;
		result_local_taken   <= loc;
		result_global_taken  <= glob;
		@(posedge clock);
		result_cond_branch   <= 1'b0;
		result_uncond_branch <= 1'b0;
		result_taken         <= 1'b0;
	endtask

	task automatic wait_for_addr(input word_t addr);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (imem_addr !== addr && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (imem_addr !== addr) begin
			$display("%s: timed out waiting for fetch address %h", cur_test, addr);
			$display("FAIL: see errors above");
			$finish;
		end
	endtask

	// move the pc with a mispredict redirect, nothing fetched meanwhile
	task automatic steer_pc(input word_t target);
		@(posedge clock);
		imem_valid       <= 1'b0;
		result_mis_pred  <= 1'b1;
		result_target_pc <= target;
		@(posedge clock);
		result_mis_pred  <= 1'b0;
		wait_for_addr(target);
	endtask

	function automatic logic [6:0] class_opcode(input int c);
		case (c)
			0:       return OP_LUI;
			1:       return OP_AUIPC;
			2:       return OP_JAL;
			3:       return OP_JALR;
			4:       return OP_BRANCH;
			5:       return OP_LOAD;
			6:       return OP_STORE;
			7:       return OP_IMM;
			8:       return OP_REG;
			9:       return OP_SYSTEM;
			default: return 7'b1111111;            // no RV32I opcode
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin : run
		word_t exp_addr;
		word_t w;
		logic  prev_valid;
		logic  v;
		clock                = 1'b0;
		reset                = 1'b1;
		imem_data            = '0;
		imem_valid           = 1'b0;
		result_pc            = '0;
		result_target_pc     = '0;
		result_cond_branch   = 1'b0;
		result_uncond_branch = 1'b0;
		result_taken         = 1'b0;
		result_local_taken   = 1'b0;
		result_global_taken  = 1'b0;
		result_mis_pred      = 1'b0;

		start_test("reset");
		for (int i = 0; i < 3; i++) begin
			@(posedge clock);
			if (i == 2)
				reset <= 1'b0;                     // third edge still in reset
			@(negedge clock);
			check_word("imem_addr in reset", '0, imem_addr);
		end
		drive_fetch(ADDI_WORD, 1'b1);
		@(negedge clock);
		check_word("first id_pc", 32'h0, id_pc);
		check_word("first id_npc", 32'h4, id_npc);
		end_test();

		start_test("stall");
		exp_addr   = 32'h0;                        // first fetch still at 0
		prev_valid = imem_valid;
		for (int i = 0; i < 40; i++) begin
			w = {7'b0, 5'($random(seed)), 5'($random(seed)), 3'b000, 5'($random(seed)), OP_REG};
			v = $random(seed);
			drive_fetch(w, v);
			@(negedge clock);
			if (prev_valid)
				exp_addr = exp_addr + 32'd4;       // step only after a valid cycle
			check_word("stepped addr", exp_addr, imem_addr);
			prev_valid = v;
		end
		end_test();

		start_test("decode");
		for (int i = 0; i < 60; i++) begin
			w      = $random(seed);
			w[6:0] = class_opcode($unsigned($random(seed)) % 11);
			drive_fetch(w, 1'b1);
		end
		drive_fetch(EBREAK_WORD, 1'b1);
		@(negedge clock);
		check_bit("ebreak halt", 1'b1, id_halt);
		drive_fetch('0, 1'b0);
		end_test();

		start_test("training");
		repeat (3)
			drive_resolve(TRAIN_PC, TRAIN_TARGET, 1'b0, 1'b1, 1'b0);
		steer_pc(TRAIN_PC);
		drive_fetch(BEQ_WORD, 1'b1);
		@(negedge clock);
		check_word("trained npc", TRAIN_TARGET, id_npc);
		check_bit("trained prediction", 1'b1, id_branch_prediction);
		end_test();

		start_test("jump");
		steer_pc(JUMP_PC);
		drive_fetch(JAL_WORD, 1'b1);
		@(negedge clock);
		check_word("jal miss npc", JUMP_PC + 32'd4, id_npc);
		drive_resolve(JUMP_PC, JUMP_TARGET, 1'b1, 1'b0, 1'b0);
		steer_pc(JUMP_PC);
		drive_fetch(JAL_WORD, 1'b1);
		@(negedge clock);
		check_word("jal hit npc", JUMP_TARGET, id_npc);
		end_test();

		start_test("mispredict");
		@(posedge clock);
		imem_data        <= ADDI_WORD;
		imem_valid       <= 1'b1;
		result_mis_pred  <= 1'b1;
		result_target_pc <= REDIRECT_PC;
		@(negedge clock);
		check_bit("squashed id_valid", 1'b0, id_valid);
		@(posedge clock);
		result_mis_pred <= 1'b0;
		imem_valid      <= 1'b0;
		@(negedge clock);
		check_word("redirect addr", REDIRECT_PC, imem_addr);
		end_test();

		drive_fetch('0, 1'b0);
		@(negedge clock);
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
rtl/fetch_pkg.sv
rtl/branch_resolve_if.sv
rtl/tournament_predictor.sv
rtl/branch_target_buffer.sv
rtl/inst_decoder.sv
rtl/fetch_stage.sv
sim/fetch_tb.sv
